/* include/afi_mux_consts.svh */
/*
 * AFI mux constants: channel count, data and chunk address widths,
 * AFI FIFO fill thresholds, channel buffer read latency
 */
`ifndef AFI_MUX_CONSTS_SVH
`define AFI_MUX_CONSTS_SVH

// channel geometry
`define AFI_NCHN         4        // compressor channels feeding the mux
`define AFI_CNT_W        8        // FIFO fill counter width, in chunks
`define AFI_CHUNK_AW     27       // 32-byte chunk address covers 4 GB
`define AFI_DATA_W       64       // AXI HP write data width

// read latency of the channel buffers, fifo_ren to fifo_rdata
`define AFI_BUF_LATENCY  2

// no burst starts above these AFI FIFO levels
`define AFI_WACOUNT_MAX  6'd29    // keeps two address slots free
`define AFI_WCOUNT_MAX   8'd119   // keeps eight data slots free

`endif

/* design/afi_mux_pkg.sv */
/*
 * Shared types of the AFI mux: channel number and mask, chunk counts,
 * corrected counts with flush flag, chunk address, burst word count
 */
`default_nettype none

package afi_mux_pkg;

    `include "afi_mux_consts.svh"

    typedef logic [$clog2(`AFI_NCHN)-1:0] chn_t;       // channel number
    typedef logic [`AFI_NCHN-1:0]         chn_mask_t;  // one bit per channel

    typedef logic [`AFI_CNT_W-1:0]  chunk_cnt_t;  // FIFO fill in chunks
    typedef logic [`AFI_CNT_W:0]    corr_cnt_t;   // msb is the flush flag

    typedef logic [`AFI_CHUNK_AW-1:0] chunk_addr_t;  // byte address >> 5

    typedef logic [3:0] word_cnt_t;    // words left in burst, also awlen
    typedef logic [2:0] chunk_inc_t;   // 1..4 chunks per burst

    typedef logic [`AFI_DATA_W-1:0] afi_data_t;

endpackage

`default_nettype wire

/* design/afi_mux_ifs.sv */
/*
 * grant_if: arbitration result, registered every cycle
 * burst_if: burst launch and internal write channel controls
 */
`default_nettype none

interface grant_if import afi_mux_pkg::*; ();

    chn_t       winner;     // channel with the largest corrected count
    corr_cnt_t  win_count;  // its count, flush flag on top
    chunk_cnt_t win_left;   // chunks left in its frame, minus one
    logic       need;       // a full burst or a flush is pending

    modport source (output winner, win_count, win_left, need);
    modport sink   (input  winner, win_count, win_left, need);

endinterface

interface burst_if import afi_mux_pkg::*; ();

    logic       launch;     // single cycle, burst start
    chn_t       chn;        // grant channel at launch, held during burst
    chunk_inc_t chunk_inc;  // valid with launch
    logic       wvalid;     // undelayed, in step with fifo_ren
    logic       wlast;      // undelayed, last word of burst

    modport source (output launch, chn, chunk_inc, wvalid, wlast);
    modport sink   (input  launch, chn, chunk_inc, wvalid, wlast);

endinterface

`default_nettype wire

/* design/chn_count_corr.sv */
/*
 * First pipeline stage: per-channel corrected FIFO counts with flush
 * flag, suspend between pre-flush and flush, frame remainder counters
 */
`default_nettype none

`include "afi_mux_consts.svh"

module chn_count_corr import afi_mux_pkg::*; (
    input  logic                       hclk,
    input  logic                       hrst,
    input  logic                       en_i,
    input  chn_mask_t                  chn_en_i,
    input  chunk_cnt_t [`AFI_NCHN-1:0] fifo_count_i,
    input  chn_mask_t                  pre_flush_i,
    input  chn_mask_t                  fifo_flush_i,
    burst_if.sink                      bus,
    input  chn_mask_t                  chunk_rd_i,    // first word of each chunk read
    output corr_cnt_t  [`AFI_NCHN-1:0] counts_o,
    output chunk_cnt_t [`AFI_NCHN-1:0] left_o
);

    chn_mask_t                  suspend;   // pre-flush seen, flush not yet
    chn_mask_t                  flush_d;   // for flush rising edge
    chunk_cnt_t [`AFI_NCHN-1:0] cnt_m1;
    chn_mask_t                  reading;   // channel owns the current burst

    always_comb begin
        for (int i = 0; i < `AFI_NCHN; i++) begin
            cnt_m1[i]  = fifo_count_i[i] - 1'b1;
            reading[i] = bus.wvalid && (bus.chn == chn_t'(i));
        end
    end

    always_ff @(posedge hclk) begin
        if (hrst) begin
            flush_d <= '0;
        end else begin
            flush_d <= fifo_flush_i;
        end
        if (hrst || !en_i) begin
            suspend <= '0;
        end else begin
            suspend <= pre_flush_i | (suspend & ~fifo_flush_i);  // held until flush
        end
        for (int i = 0; i < `AFI_NCHN; i++) begin
            if (hrst || (fifo_count_i[i] == '0) || !chn_en_i[i] || suspend[i]) begin
                counts_o[i] <= '0;                                // not a candidate
            end else if (reading[i]) begin
                // chunk in progress is already taken
                counts_o[i] <= (cnt_m1[i] == '0) ? '0 : {fifo_flush_i[i], cnt_m1[i]};
            end else begin
                counts_o[i] <= {fifo_flush_i[i], fifo_count_i[i]};
            end
            if (fifo_flush_i[i] && !flush_d[i]) begin
                left_o[i] <= cnt_m1[i] - chunk_rd_i[i];           // frame size at flush
            end else if (chunk_rd_i[i]) begin
                left_o[i] <= left_o[i] - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* design/chn_arbiter.sv */
/*
 * Two-level largest-count arbitration, pairs 0/1 and 2/3 first,
 * then the pair winners; ties go to the lower channel
 */
`default_nettype none

`include "afi_mux_consts.svh"

module chn_arbiter import afi_mux_pkg::*; (
    input  logic                       hclk,
    input  corr_cnt_t  [`AFI_NCHN-1:0] counts_i,
    input  chunk_cnt_t [`AFI_NCHN-1:0] left_i,
    grant_if.source                    grant
);

    logic       [1:0] pair_hi;  // odd channel of the pair is larger
    corr_cnt_t  [1:0] cnt1;     // first level winning counts
    chunk_cnt_t [1:0] left1;
    logic       [1:0] win1;
    logic             hi;       // pair 2/3 beats pair 0/1

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            pair_hi[p] = counts_i[2*p+1] > counts_i[2*p];  // strict, tie keeps even
        end
    end

    assign hi = cnt1[1] > cnt1[0];

    always_ff @(posedge hclk) begin
        for (int p = 0; p < 2; p++) begin
            win1[p]  <= pair_hi[p];
            cnt1[p]  <= counts_i[2*p + pair_hi[p]];
            left1[p] <= left_i[2*p + pair_hi[p]];
        end
        // second level
        grant.winner    <= {hi, win1[hi]};
        grant.win_count <= cnt1[hi];
        grant.win_left  <= left1[hi];
        grant.need      <= |cnt1[hi][`AFI_CNT_W:2];  // flag or four chunks
    end

endmodule

`default_nettype wire

/* design/burst_ctrl.sv */
/*
 * Burst launch from grant and AFI FIFO levels, word countdown,
 * one-hot FIFO read enables, internal wvalid/wlast, awvalid/awlen/awid
 */
`default_nettype none

`include "afi_mux_consts.svh"

module burst_ctrl import afi_mux_pkg::*; (
    input  logic       hclk,
    input  logic       hrst,
    input  logic       en_i,
    input  logic [5:0] afi_wacount_i,
    input  logic [7:0] afi_wcount_i,
    grant_if.sink      grant,
    input  logic       ptr_resetting_i,
    burst_if.source    bus,
    output chn_mask_t  chunk_rd_o,
    output chn_mask_t  fifo_ren_o,
    output logic       afi_awvalid_o,
    output word_cnt_t  afi_awlen_o,
    output logic [5:0] afi_awid_o
);

    logic       ready;    // room in both AFI FIFOs
    logic       busy;     // burst data phase
    word_cnt_t  wleft;    // words left after the current one
    chn_t       chn_r;
    logic [1:0] aw_dly;   // launch delayed to awvalid
    chunk_inc_t inc_w;
    logic       launch;

    assign launch = en_i && !busy && ready && grant.need && !ptr_resetting_i;

    // full bursts unless a flushed frame is ending
    assign inc_w = (!grant.win_count[`AFI_CNT_W] || (|grant.win_left[`AFI_CNT_W-1:2])) ?
                   3'd4 : {1'b0, grant.win_left[1:0]} + 3'd1;

    assign fifo_ren_o = chn_mask_t'(busy) << chn_r;
    assign chunk_rd_o = (wleft[1:0] == 2'b11) ? fifo_ren_o : '0;  // first word of chunk
    assign afi_awvalid_o = aw_dly[1];

    assign bus.launch    = launch;
    assign bus.chn       = busy ? chn_r : grant.winner;
    assign bus.chunk_inc = inc_w;
    assign bus.wvalid    = busy;
    assign bus.wlast     = busy && (wleft == '0);

    always_ff @(posedge hclk) begin
        ready <= !hrst && en_i &&
                 (afi_wacount_i <= `AFI_WACOUNT_MAX) && (afi_wcount_i <= `AFI_WCOUNT_MAX);
        if (hrst || !en_i) begin
            busy   <= 1'b0;
            wleft  <= '0;
            aw_dly <= '0;
        end else begin
            busy   <= launch || (busy && !bus.wlast);  // free the cycle after wlast
            aw_dly <= {aw_dly[0], launch};
            if (launch) begin
                wleft <= {inc_w[1:0] - 2'd1, 2'b11};   // 4 * inc - 1
            end else if (wleft != '0) begin
                wleft <= wleft - 1'b1;
            end
        end
        if (launch) begin
            chn_r <= grant.winner;
        end
        if (aw_dly[0]) begin
            afi_awlen_o <= wleft;                          // still the full count here
            afi_awid_o  <= {2'b00, wleft[3:2], chn_r};     // burst length and channel
        end
    end

endmodule

`default_nettype wire

/* design/chunk_ptr.sv */
/*
 * Per-channel ring buffer start, length and current offset,
 * FIFO reset pulses, burst chunk address with wrap-around
 */
`default_nettype none

`include "afi_mux_consts.svh"

module chunk_ptr import afi_mux_pkg::*; (
    input  logic        hclk,
    input  logic        hrst,
    input  logic        en_i,
    input  logic        sa_len_we_i,
    input  logic [2:0]  sa_len_wa_i,   // [2] length, [1:0] channel
    input  chunk_addr_t sa_len_d_i,
    output chn_mask_t   fifo_rst_o,
    burst_if.sink       bus,
    output logic        ptr_resetting_o,
    output logic [31:0] afi_awaddr_o
);

    chunk_addr_t start [`AFI_NCHN];
    chunk_addr_t len   [`AFI_NCHN];   // ring size in chunks
    chunk_addr_t offs  [`AFI_NCHN];   // next chunk within the ring
    chn_mask_t   rst_r;
    logic        en_d;
    chunk_addr_t offs_inc;
    chunk_addr_t chunk_addr;

    assign offs_inc        = offs[bus.chn] + bus.chunk_inc;
    assign fifo_rst_o      = rst_r;
    assign ptr_resetting_o = |rst_r;                 // blocks launch
    assign afi_awaddr_o    = {chunk_addr, 5'b0};

    always_ff @(posedge hclk) begin
        en_d <= !hrst && en_i;
        if (hrst) begin
            rst_r <= '0;
        end else if (en_i && !en_d) begin
            rst_r <= '1;                             // all channels on enable
        end else begin
            rst_r <= (sa_len_we_i && en_i) ? chn_mask_t'(1) << sa_len_wa_i[1:0] : '0;
        end
        if (sa_len_we_i) begin
            if (sa_len_wa_i[2]) begin
                len[sa_len_wa_i[1:0]] <= sa_len_d_i;
            end else begin
                start[sa_len_wa_i[1:0]] <= sa_len_d_i;
            end
        end
        for (int i = 0; i < `AFI_NCHN; i++) begin
            if (hrst || rst_r[i]) begin
                offs[i] <= '0;
            end else if (bus.launch && (bus.chn == chn_t'(i))) begin
                // wrap back toward start
                offs[i] <= (offs_inc >= len[i]) ? offs_inc - len[i] : offs_inc;
            end
        end
        if (bus.launch) begin
            chunk_addr <= start[bus.chn] + offs[bus.chn];  // held through awvalid
        end
    end

endmodule

`default_nettype wire

/* design/wdata_path.sv */
/*
 * Write data path: buffer latency delay of wvalid/wlast and of the
 * data enable and channel select, registered 64-bit data mux
 */
`default_nettype none

`include "afi_mux_consts.svh"

module wdata_path import afi_mux_pkg::*; (
    input  logic                      hclk,
    input  logic                      hrst,
    input  logic                      en_i,
    burst_if.sink                     bus,
    input  afi_data_t [`AFI_NCHN-1:0] fifo_rdata_i,
    output afi_data_t                 afi_wdata_o,
    output logic                      afi_wvalid_o,
    output logic                      afi_wlast_o
);

    logic [`AFI_BUF_LATENCY:0]   vld_sr;   // latency plus the data register
    logic [`AFI_BUF_LATENCY:0]   last_sr;
    logic [`AFI_BUF_LATENCY-1:0] den_sr;   // one stage shorter
    chn_t [`AFI_BUF_LATENCY-1:0] sel_sr;

    assign afi_wvalid_o = vld_sr[`AFI_BUF_LATENCY];
    assign afi_wlast_o  = last_sr[`AFI_BUF_LATENCY];

    always_ff @(posedge hclk) begin
        if (hrst || !en_i) begin
            vld_sr  <= '0;
            last_sr <= '0;
            den_sr  <= '0;
        end else begin
            vld_sr  <= (vld_sr << 1) | bus.wvalid;
            last_sr <= (last_sr << 1) | bus.wlast;
            den_sr  <= (den_sr << 1) | bus.wvalid;
        end
        sel_sr[0] <= bus.chn;
        for (int i = 1; i < `AFI_BUF_LATENCY; i++) begin
            sel_sr[i] <= sel_sr[i-1];
        end
        if (den_sr[`AFI_BUF_LATENCY-1]) begin
            afi_wdata_o <= fifo_rdata_i[sel_sr[`AFI_BUF_LATENCY-1]];  // buffer word is valid now
        end
    end

endmodule

`default_nettype wire

/* design/afi_mux_top.sv */
/*
 * AFI mux top level: four compressor channel FIFOs merged into
 * AXI HP write bursts, pipeline stage instances and wiring
 */
`default_nettype none

`include "afi_mux_consts.svh"

module afi_mux_top import afi_mux_pkg::*; (
    input  logic        hclk,
    input  logic        hrst,
    input  logic        en_i,          // global enable
    input  chn_mask_t   chn_en_i,      // per-channel enable
    input  logic        sa_len_we_i,
    input  logic [2:0]  sa_len_wa_i,   // [2] length, [1:0] channel
    input  chunk_addr_t sa_len_d_i,    // in 32-byte chunks
    // channel 0
    input  chunk_cnt_t  fifo_count0_i,
    input  afi_data_t   fifo_rdata0_i,
    input  logic        pre_flush0_i,
    input  logic        fifo_flush0_i,
    // channel 1
    input  chunk_cnt_t  fifo_count1_i,
    input  afi_data_t   fifo_rdata1_i,
    input  logic        pre_flush1_i,
    input  logic        fifo_flush1_i,
    // channel 2
    input  chunk_cnt_t  fifo_count2_i,
    input  afi_data_t   fifo_rdata2_i,
    input  logic        pre_flush2_i,
    input  logic        fifo_flush2_i,
    // channel 3
    input  chunk_cnt_t  fifo_count3_i,
    input  afi_data_t   fifo_rdata3_i,
    input  logic        pre_flush3_i,
    input  logic        fifo_flush3_i,
    output chn_mask_t   fifo_ren_o,
    output chn_mask_t   fifo_rst_o,
    // AXI HP write side
    input  logic [5:0]  afi_wacount_i,
    input  logic [7:0]  afi_wcount_i,
    output logic [31:0] afi_awaddr_o,
    output logic        afi_awvalid_o,
    output word_cnt_t   afi_awlen_o,
    output logic [5:0]  afi_awid_o,
    output afi_data_t   afi_wdata_o,
    output logic        afi_wvalid_o,
    output logic        afi_wlast_o
);

    logic                       ptr_resetting;
    chn_mask_t                  chunk_rd;
    corr_cnt_t  [`AFI_NCHN-1:0] counts;
    chunk_cnt_t [`AFI_NCHN-1:0] left;

    grant_if u_grant_if ();
    burst_if u_burst_if ();

    chn_count_corr u_chn_count_corr (
        .hclk         (hclk),
        .hrst         (hrst),
        .en_i         (en_i),
        .chn_en_i     (chn_en_i),
        .fifo_count_i ({fifo_count3_i, fifo_count2_i, fifo_count1_i, fifo_count0_i}),
        .pre_flush_i  ({pre_flush3_i, pre_flush2_i, pre_flush1_i, pre_flush0_i}),
        .fifo_flush_i ({fifo_flush3_i, fifo_flush2_i, fifo_flush1_i, fifo_flush0_i}),
        .bus          (u_burst_if.sink),
        .chunk_rd_i   (chunk_rd),
        .counts_o     (counts),
        .left_o       (left)
    );

    chn_arbiter u_chn_arbiter (
        .hclk     (hclk),
        .counts_i (counts),
        .left_i   (left),
        .grant    (u_grant_if.source)
    );

    burst_ctrl u_burst_ctrl (
        .hclk            (hclk),
        .hrst            (hrst),
        .en_i            (en_i),
        .afi_wacount_i   (afi_wacount_i),
        .afi_wcount_i    (afi_wcount_i),
        .grant           (u_grant_if.sink),
        .ptr_resetting_i (ptr_resetting),
        .bus             (u_burst_if.source),
        .chunk_rd_o      (chunk_rd),
        .fifo_ren_o      (fifo_ren_o),
        .afi_awvalid_o   (afi_awvalid_o),
        .afi_awlen_o     (afi_awlen_o),
        .afi_awid_o      (afi_awid_o)
    );

    chunk_ptr u_chunk_ptr (
        .hclk            (hclk),
        .hrst            (hrst),
        .en_i            (en_i),
        .sa_len_we_i     (sa_len_we_i),
        .sa_len_wa_i     (sa_len_wa_i),
        .sa_len_d_i      (sa_len_d_i),
        .fifo_rst_o      (fifo_rst_o),
        .bus             (u_burst_if.sink),
        .ptr_resetting_o (ptr_resetting),
        .afi_awaddr_o    (afi_awaddr_o)
    );

    wdata_path u_wdata_path (
        .hclk         (hclk),
        .hrst         (hrst),
        .en_i         (en_i),
        .bus          (u_burst_if.sink),
        .fifo_rdata_i ({fifo_rdata3_i, fifo_rdata2_i, fifo_rdata1_i, fifo_rdata0_i}),
        .afi_wdata_o  (afi_wdata_o),
        .afi_wvalid_o (afi_wvalid_o),
        .afi_wlast_o  (afi_wlast_o)
    );

endmodule

`default_nettype wire

/* verification/afi_mux_props.sv */
/*
 * Concurrent assertions on the AFI mux top-level ports,
 * bound to afi_mux_top
 */
`default_nettype none

module afi_mux_props import afi_mux_pkg::*; (
    input logic      hclk,
    input logic      hrst,
    input chn_mask_t chn_en_i,
    input chn_mask_t fifo_ren_i,
    input logic      afi_awvalid_i,
    input logic      afi_wvalid_i,
    input logic      afi_wlast_i
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_cnt = 0;   // failed assertions so far

    a_ren_onehot: assert property (@(posedge hclk) disable iff (hrst)
        $onehot0(fifo_ren_i))
        else begin
            $error("more than one FIFO read enable is high");
            fail_cnt++;
        end

    a_aw_pulse: assert property (@(posedge hclk) disable iff (hrst)
        afi_awvalid_i |=> !afi_awvalid_i)
        else begin
            $error("awvalid held for more than one cycle");
            fail_cnt++;
        end

    a_wlast_valid: assert property (@(posedge hclk) disable iff (hrst)
        afi_wlast_i |-> afi_wvalid_i)
        else begin
            $error("wlast without wvalid");
            fail_cnt++;
        end

    a_ren_enabled: assert property (@(posedge hclk) disable iff (hrst)
        (fifo_ren_i & ~chn_en_i) == '0)
        else begin
            $error("read enable on a disabled channel");
            fail_cnt++;
        end

endmodule

bind afi_mux_top afi_mux_props u_afi_mux_props (
    .hclk          (hclk),
    .hrst          (hrst),
    .chn_en_i      (chn_en_i),
    .fifo_ren_i    (fifo_ren_o),
    .afi_awvalid_i (afi_awvalid_o),
    .afi_wvalid_i  (afi_wvalid_o),
    .afi_wlast_i   (afi_wlast_o)
);

`default_nettype wire

/* verification/afi_mux_tb.sv */
/*
 * AFI mux testbench: clock, reset, channel FIFO models, stimulus table,
 * expected burst order replayed from the count rule, typed checks, timeout
 */
`default_nettype none

`include "afi_mux_consts.svh"

module afi_mux_tb import afi_mux_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NROWS = 5;
    localparam int LIMIT = NROWS * 400;  // cycles
    localparam int LAT   = `AFI_BUF_LATENCY;

    typedef struct packed {
        chn_mask_t               en;
        chn_mask_t               pre;    // pre-flush, flush follows later
        chn_mask_t               fl;     // flushed frames
        logic                    wr;     // rewrite start/length
        chunk_addr_t             base;   // channel n starts at base + n*0x400
        chunk_addr_t             len;
        chunk_cnt_t [3:0]        cnt;
    } row_t;

    row_t rows [NROWS] = '{
        '{4'b0001, 4'b0000, 4'b0000, 1'b1, 27'h100,  27'd64, {8'd0, 8'd0, 8'd0, 8'd8}},
        '{4'b0011, 4'b0000, 4'b0000, 1'b1, 27'h2000, 27'd16, {8'd0, 8'd0, 8'd8, 8'd4}},
        '{4'b1101, 4'b0100, 4'b0100, 1'b1, 27'h3000, 27'd32, {8'd0, 8'd7, 8'd4, 8'd0}},
        '{4'b0100, 4'b0000, 4'b0100, 1'b1, 27'h4000, 27'd6,  {8'd0, 8'd6, 8'd0, 8'd0}},
        '{4'b0100, 4'b0000, 4'b0000, 1'b0, 27'h4000, 27'd6,  {8'd0, 8'd4, 8'd0, 8'd0}}
    };

    logic        hclk;
    logic        hrst;
    logic        en;
    chn_mask_t   chn_en;
    logic        sa_we;
    logic [2:0]  sa_wa;
    chunk_addr_t sa_d;
    logic [5:0]  afi_wacount;
    logic [7:0]  afi_wcount;
    chn_mask_t   fifo_ren, fifo_rst;
    logic [31:0] afi_awaddr;
    logic        afi_awvalid, afi_wvalid, afi_wlast;
    word_cnt_t   afi_awlen;
    logic [5:0]  afi_awid;
    afi_data_t   afi_wdata;

    // FIFO model state
    chunk_cnt_t  cnt [`AFI_NCHN];
    chn_mask_t   flush_m = '0;
    chn_mask_t   pre_m = '0;
    chn_mask_t   pre_hold = '0;          // channels that must stay unread
    chn_mask_t   dec_pend = '0;
    int          widx [`AFI_NCHN];
    afi_data_t   pipe [`AFI_NCHN][LAT+1];

    // expected bursts, and bursts waiting for their data
    chn_t        eq_ch[$];
    chunk_addr_t eq_addr[$];
    word_cnt_t   eq_len[$];
    chn_t        dq_ch[$];
    word_cnt_t   dq_len[$];
    chunk_addr_t offs [`AFI_NCHN];
    int          exp_idx [`AFI_NCHN];
    int          wcnt = 0;
    int          cycles = 0;
    logic [31:0] lfsr = 32'h7ad;

    afi_mux_top u_afi_mux_top (
        .hclk(hclk), .hrst(hrst), .en_i(en), .chn_en_i(chn_en),
        .sa_len_we_i(sa_we), .sa_len_wa_i(sa_wa), .sa_len_d_i(sa_d),
        .fifo_count0_i(cnt[0]), .fifo_rdata0_i(pipe[0][LAT]),
        .pre_flush0_i(pre_m[0]), .fifo_flush0_i(flush_m[0]),
        .fifo_count1_i(cnt[1]), .fifo_rdata1_i(pipe[1][LAT]),
        .pre_flush1_i(pre_m[1]), .fifo_flush1_i(flush_m[1]),
        .fifo_count2_i(cnt[2]), .fifo_rdata2_i(pipe[2][LAT]),
        .pre_flush2_i(pre_m[2]), .fifo_flush2_i(flush_m[2]),
        .fifo_count3_i(cnt[3]), .fifo_rdata3_i(pipe[3][LAT]),
        .pre_flush3_i(pre_m[3]), .fifo_flush3_i(flush_m[3]),
        .fifo_ren_o(fifo_ren), .fifo_rst_o(fifo_rst),
        .afi_wacount_i(afi_wacount), .afi_wcount_i(afi_wcount),
        .afi_awaddr_o(afi_awaddr), .afi_awvalid_o(afi_awvalid), .afi_awlen_o(afi_awlen),
        .afi_awid_o(afi_awid), .afi_wdata_o(afi_wdata), .afi_wvalid_o(afi_wvalid),
        .afi_wlast_o(afi_wlast)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32,22,2,1
    endfunction

    function automatic afi_data_t make_word(input int ch, input int idx);
        return {8'(ch), 56'(idx)};                      // channel, running index
    endfunction

    task automatic stop_run();
        $display("Errors found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic fail_plain(input string msg);
        $display("%0t %s", $time, msg);
        stop_run();
    endtask

    task automatic check_addr(input string name, input chunk_addr_t got, input chunk_addr_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_len(input string name, input word_cnt_t got, input word_cnt_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_data(input string name, input afi_data_t got, input afi_data_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_chn(input string name, input chn_t got, input chn_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_mask(input string name, input chn_mask_t got, input chn_mask_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    // largest remaining count wins, flush flag on top, ties to the lower channel
    task automatic build_expected(input int r);
        int       rem [`AFI_NCHN];
        int       best;
        int       inc;
        logic [8:0] key;
        logic [8:0] best_key;
        for (int ch = 0; ch < `AFI_NCHN; ch++) begin
            rem[ch] = rows[r].en[ch] ? int'(rows[r].cnt[ch]) : 0;
            if (rows[r].wr) offs[ch] = '0;
        end
        while (1) begin
            best = -1;
            best_key = '0;
            for (int ch = 0; ch < `AFI_NCHN; ch++) begin
                key = {rows[r].fl[ch], 8'(rem[ch])};
                if (rem[ch] > 0 && (rem[ch] >= 4 || rows[r].fl[ch]) && key > best_key) begin
                    best = ch;
                    best_key = key;
                end
            end
            if (best < 0) break;
            inc = (rows[r].fl[best] && rem[best] < 4) ? rem[best] : 4;
            eq_ch.push_back(chn_t'(best));
            eq_addr.push_back(rows[r].base + chunk_addr_t'(best * 'h400) + offs[best]);
            eq_len.push_back(word_cnt_t'(4 * inc - 1));
            offs[best] = offs[best] + inc;
            if (offs[best] >= rows[r].len) offs[best] = offs[best] - rows[r].len;  // ring wrap
            rem[best] -= inc;
        end
    endtask

    task automatic write_ptr(input logic [2:0] wa, input chunk_addr_t d);
        sa_we = 1'b1;
        sa_wa = wa;
        sa_d  = d;
        @(negedge hclk);
    endtask

    task automatic wait_drain(input chn_mask_t mask);
        logic pending;
        do begin
            pending = (eq_ch.size() != 0) || (dq_ch.size() != 0);
            for (int ch = 0; ch < `AFI_NCHN; ch++) begin
                if (mask[ch] && cnt[ch] != '0) pending = 1'b1;
            end
            if (pending) @(negedge hclk);
        end while (pending);
        repeat (8) @(negedge hclk);
    endtask

    task automatic run_row(input int r);
        chunk_addr_t start;
        chn_en = rows[r].en;
        if (rows[r].wr) begin
            for (int ch = 0; ch < `AFI_NCHN; ch++) begin
                start = rows[r].base + chunk_addr_t'(ch * 'h400);
                write_ptr({1'b0, 2'(ch)}, start);
                write_ptr({1'b1, 2'(ch)}, rows[r].len);
            end
            sa_we = 1'b0;
        end
        build_expected(r);
        if (rows[r].pre != '0) begin
            pre_m = rows[r].pre;                     // single cycle pulse
            @(negedge hclk);
            pre_m = '0;
            pre_hold = rows[r].pre;
        end
        for (int ch = 0; ch < `AFI_NCHN; ch++) cnt[ch] = rows[r].cnt[ch];
        flush_m = rows[r].fl & ~rows[r].pre;
        if (rows[r].pre != '0) begin
            repeat (40) @(negedge hclk);             // suspended channel stays idle
            pre_hold = '0;
            flush_m = flush_m | rows[r].pre;
        end
        wait_drain(rows[r].en);
    endtask

    initial begin
        hclk = 1'b0;
        forever #4 hclk = ~hclk;
    end

    always @(posedge hclk) begin
        cycles++;
        if (cycles > LIMIT) fail_plain("timeout, the run did not finish in time");
    end

    // AFI FIFO levels, occasionally at a blocking fill
    always @(negedge hclk) begin
        logic [2:0] pick;
        for (int b = 0; b < 3; b++) begin
            lfsr = lfsr_step(lfsr);
            pick[b] = lfsr[0];
        end
        afi_wacount = (pick == 3'b111) ? 6'd31 : 6'd0;
        afi_wcount  = (pick == 3'b111) ? 8'd124 : 8'd0;
    end

    // channel FIFO models, count drops in the cycle after a chunk's last read
    always @(negedge hclk) begin
        for (int ch = 0; ch < `AFI_NCHN; ch++) begin
            if (dec_pend[ch]) begin
                cnt[ch] = cnt[ch] - 1'b1;
                dec_pend[ch] = 1'b0;
                if (cnt[ch] == '0) flush_m[ch] = 1'b0;  // frame done
            end
            for (int i = LAT; i > 0; i--) pipe[ch][i] = pipe[ch][i-1];
            pipe[ch][0] = '0;
            if (fifo_ren[ch] === 1'b1) begin
                pipe[ch][0] = make_word(ch, widx[ch]);
                widx[ch]++;
                if (widx[ch] % 4 == 0) dec_pend[ch] = 1'b1;
            end
        end
    end

    always @(negedge hclk) begin
        chn_t ch;
        if (!hrst) begin
            if (u_afi_mux_top.u_afi_mux_props.fail_cnt != 0) begin
                fail_plain("a bound assertion on the DUT ports failed");
            end else if ((fifo_ren & ~chn_en) != '0) begin
                fail_plain("a FIFO read enable went to a disabled channel");
            end else if ((fifo_ren & pre_hold) != '0) begin
                fail_plain("a channel in pre-flush was read before its flush");
            end else begin
                if (afi_wvalid) begin
                    if (dq_ch.size() == 0) begin
                        fail_plain("write data came without a burst address");
                    end else begin
                        ch = dq_ch[0];
                        check_data("afi_wdata", afi_wdata, make_word(ch, exp_idx[ch]));
                        exp_idx[ch]++;
                        wcnt++;
                        check_flag("afi_wlast", afi_wlast, wcnt == int'(dq_len[0]) + 1);
                        if (afi_wlast) begin
                            void'(dq_ch.pop_front());
                            void'(dq_len.pop_front());
                            wcnt = 0;
                        end
                    end
                end
                if (afi_awvalid) begin
                    if (eq_ch.size() == 0) begin
                        fail_plain("an address burst came that was not expected");
                    end else begin
                        check_chn("afi_awid", chn_t'(afi_awid[1:0]), eq_ch[0]);
                        check_addr("afi_awaddr", afi_awaddr[31:5], eq_addr[0]);
                        check_len("afi_awlen", afi_awlen, eq_len[0]);
                        dq_ch.push_back(eq_ch.pop_front());
                        dq_len.push_back(eq_len.pop_front());
                        void'(eq_addr.pop_front());
                    end
                end
            end
        end
    end

    initial begin
        hrst = 1'b1;
        en = 1'b0;
        chn_en = '0;
        sa_we = 1'b0;
        sa_wa = '0;
        sa_d = '0;
        afi_wacount = '0;
        afi_wcount = '0;
        for (int ch = 0; ch < `AFI_NCHN; ch++) begin
            cnt[ch] = '0;
            widx[ch] = 0;
            exp_idx[ch] = 0;
            offs[ch] = '0;
            for (int i = 0; i <= LAT; i++) pipe[ch][i] = '0;
        end
        repeat (5) @(posedge hclk);
        @(negedge hclk);
        hrst = 1'b0;
        repeat (10) begin                            // idle before enable
            @(negedge hclk);
            check_mask("fifo_ren_o", fifo_ren, '0);
            check_mask("fifo_rst_o", fifo_rst, '0);
            check_flag("afi_awvalid_o", afi_awvalid, 1'b0);
            check_flag("afi_wvalid_o", afi_wvalid, 1'b0);
        end
        en = 1'b1;
        @(negedge hclk);
        check_mask("fifo_rst_o", fifo_rst, '1);      // all channels on enable
        @(negedge hclk);
        check_mask("fifo_rst_o", fifo_rst, '0);
        for (int r = 0; r < NROWS; r++) run_row(r);
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+include
design/afi_mux_pkg.sv
design/afi_mux_ifs.sv
design/chn_count_corr.sv
design/chn_arbiter.sv
design/burst_ctrl.sv
design/chunk_ptr.sv
design/wdata_path.sv
design/afi_mux_top.sv
verification/afi_mux_props.sv
verification/afi_mux_tb.sv

/* Bender.yml */
package:
  name: afi_mux

sources:
  - include_dirs:
      - include
    files:
      - design/afi_mux_pkg.sv
      - design/afi_mux_ifs.sv
      - design/chn_count_corr.sv
      - design/chn_arbiter.sv
      - design/burst_ctrl.sv
      - design/chunk_ptr.sv
      - design/wdata_path.sv
      - design/afi_mux_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/afi_mux_props.sv
      - verification/afi_mux_tb.sv
